/* common/bridge_macros.svh */
/*
 * Widths, slave count and address map of the write bridge.
 * Included by the package and by every module that sizes a port.
 */
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

`define AXI_ID_BITS     4
`define AXI_IDS_BITS    8
`define AXI_ADDR_BITS   32
`define AXI_DATA_BITS   32
`define AXI_STRB_BITS   4
`define AXI_LEN_BITS    4
`define AXI_SIZE_BITS   3

`define NUM_SLAVES      5
`define SLAVE_SEL_BITS  3

// Matched against addr[31:16]
`define REGION0_HI      16'h0001
`define REGION1_HI      16'h0002
`define REGION2_HI      16'h1000
`define REGION3_HI      16'h1001
// Matched against addr[31:24]
`define REGION4_HI      8'h20

`define RESP_OKAY       2'b00
`define RESP_DECERR     2'b11

`endif

/* common/bridge_pkg.sv */
/*
 * Channel payload types and bridge state shared by all bridge modules.
 * Referenced by scoped name, e.g. bridge_pkg::aw_master_t.
 */
`include "bridge_macros.svh"

package bridge_pkg;

    // Master side write address
    typedef struct packed {
        logic [`AXI_ID_BITS-1:0]   id;
        logic [`AXI_ADDR_BITS-1:0] addr;
        logic [`AXI_LEN_BITS-1:0]  len;
        logic [`AXI_SIZE_BITS-1:0] size;
        logic [1:0]                burst;
    } aw_master_t;

    // Slave side write address, wider id
    typedef struct packed {
        logic [`AXI_IDS_BITS-1:0]  id;
        logic [`AXI_ADDR_BITS-1:0] addr;
        logic [`AXI_LEN_BITS-1:0]  len;
        logic [`AXI_SIZE_BITS-1:0] size;
        logic [1:0]                burst;
    } aw_slave_t;

    typedef struct packed {
        logic [`AXI_DATA_BITS-1:0] data;
        logic [`AXI_STRB_BITS-1:0] strb;
        logic                      last;
    } w_payload_t;

    typedef struct packed {
        logic [`AXI_ID_BITS-1:0] id;
        logic [1:0]              resp;
    } b_master_t;

    typedef struct packed {
        logic [`AXI_IDS_BITS-1:0] id;
        logic [1:0]               resp;
    } b_slave_t;

    typedef enum logic [1:0] {
        IDLE,
        ROUTE,
        DRAIN,
        ERR_RESP
    } bridge_state_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the write bridge testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f write_bridge.f --top-module tb_write_bridge -o tb_write_bridge

out=$(./obj_dir/tb_write_bridge)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
else
    exit 1
fi

/* sim/tb_write_bridge.sv */
/*
 * Testbench for the write bridge. Runs a table of bursts through five
 * randomly stalling slave models and checks routing, data and responses.
 */
`timescale 1ns/100ps
`include "bridge_macros.svh"

module tb_write_bridge;

    localparam int NUM_ROWS = 8;

    typedef struct {
        logic [31:0] addr;
        logic [3:0]  len;
        logic [3:0]  id;
        logic [31:0] seed;
        int          target;
        logic [1:0]  resp;
    } row_t;

    logic                              ACLK;
    logic                              ARESETn;
    bridge_pkg::aw_master_t            aw;
    logic                              aw_valid;
    logic                              aw_ready;
    bridge_pkg::w_payload_t            w;
    logic                              w_valid;
    logic                              w_ready;
    bridge_pkg::b_master_t             b;
    logic                              b_valid;
    logic                              b_ready;
    bridge_pkg::aw_slave_t             s_aw [`NUM_SLAVES];
    logic [`NUM_SLAVES-1:0]            s_aw_valid;
    logic [`NUM_SLAVES-1:0]            s_aw_ready;
    bridge_pkg::w_payload_t            s_w [`NUM_SLAVES];
    logic [`NUM_SLAVES-1:0]            s_w_valid;
    logic [`NUM_SLAVES-1:0]            s_w_ready;
    bridge_pkg::b_slave_t              s_b [`NUM_SLAVES];
    logic [`NUM_SLAVES-1:0]            s_b_valid;
    logic [`NUM_SLAVES-1:0]            s_b_ready;

    row_t                              rows [NUM_ROWS];
    int                                errors;
    int                                tests_failed;
    int                                row_index;
    int                                exp_target;
    // Slave model records, written only by the slave process
    bridge_pkg::aw_slave_t             aw_rec [`NUM_SLAVES];
    int                                aw_count [`NUM_SLAVES];
    int                                beat_count [`NUM_SLAVES];
    int                                b_count [`NUM_SLAVES];
    logic [31:0]                       beat_data [`NUM_SLAVES][16];
    logic [3:0]                        beat_strb [`NUM_SLAVES][16];
    logic                              beat_last [`NUM_SLAVES][16];
    int                                stray_count;

    write_bridge_top uut (.*);

    initial begin
        ACLK = 1'b0;
        forever #5 ACLK = ~ACLK;
    end

    function automatic logic [31:0] next_random(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] beat_word(logic [31:0] seed, int k);
        return (seed ^ (32'(k) * 32'h0101_0101)) + 32'(k);
    endfunction

    function automatic logic [3:0] beat_strobe(int k);
        return 4'hf ^ 4'(k % 4);
    endfunction

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] expected);
        assert (got == expected) else begin
            $display("Mismatch %s: got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    // Five slave models: sample transfers at negedge, drive 1 ns after posedge
    initial begin
        logic [31:0]            rng;
        logic [`NUM_SLAVES-1:0] resp_due;
        logic [`NUM_SLAVES-1:0] b_taken;
        logic                   in_reset;
        int                     seen_row;
        rng = 32'h8c84;
        resp_due = '0;
        seen_row = 0;
        s_aw_ready = '0;
        s_w_ready = '0;
        s_b_valid = '0;
        for (int i = 0; i < `NUM_SLAVES; i++) begin
            s_b[i] = '0;
            aw_rec[i] = '0;
            aw_count[i] = 0;
            beat_count[i] = 0;
            b_count[i] = 0;
        end
        stray_count = 0;
        forever begin
            @(negedge ACLK);
            b_taken = '0;
            if (row_index != seen_row) begin
                seen_row = row_index;
                stray_count = 0;
                for (int i = 0; i < `NUM_SLAVES; i++) begin
                    aw_count[i] = 0;
                    beat_count[i] = 0;
                    b_count[i] = 0;
                end
            end
            for (int i = 0; i < `NUM_SLAVES; i++) begin
                if (s_aw_valid[i] && s_aw_ready[i]) begin
                    aw_rec[i] = s_aw[i];
                    aw_count[i]++;
                end
                if (s_w_valid[i] && s_w_ready[i]) begin
                    if (beat_count[i] < 16) begin
                        beat_data[i][beat_count[i]] = s_w[i].data;
                        beat_strb[i][beat_count[i]] = s_w[i].strb;
                        beat_last[i][beat_count[i]] = s_w[i].last;
                    end
                    beat_count[i]++;
                    if (s_w[i].last) resp_due[i] = 1'b1;
                end
                if (s_b_valid[i] && s_b_ready[i]) begin
                    b_taken[i] = 1'b1;
                    b_count[i]++;
                end
                if ((s_aw_valid[i] || s_w_valid[i] || s_b_ready[i]) && i != exp_target) begin
                    stray_count++;
                end
            end
            @(posedge ACLK);
            in_reset = !ARESETn;
            #1;
            if (in_reset) begin
                s_aw_ready = '0;
                s_w_ready = '0;
            end else begin
                rng = next_random(rng);
                for (int i = 0; i < `NUM_SLAVES; i++) begin
                    s_aw_ready[i] = rng[20+i];
                    s_w_ready[i] = rng[25+i];
                    if (b_taken[i]) begin
                        s_b_valid[i] = 1'b0;
                        s_b[i] = '0;
                    end else if (resp_due[i]) begin
                        s_b_valid[i] = 1'b1;
                        s_b[i] = '{id: aw_rec[i].id, resp: `RESP_OKAY};
                        resp_due[i] = 1'b0;
                    end
                end
            end
        end
    end

    task automatic run_row(int r);
        int                    errs_before;
        int                    t;
        logic                  hs;
        bridge_pkg::b_master_t got_b;
        errs_before = errors;
        t = rows[r].target;
        row_index = r + 1;
        exp_target = t;
        aw = '{id: rows[r].id, addr: rows[r].addr, len: rows[r].len, size: 3'd2, burst: 2'b01};
        aw_valid = 1'b1;
        do begin
            @(negedge ACLK);
            hs = aw_ready;
            @(posedge ACLK);
            #1;
        end while (!hs);
        aw_valid = 1'b0;
        for (int k = 0; k <= int'(rows[r].len); k++) begin
            w = '{data: beat_word(rows[r].seed, k), strb: beat_strobe(k),
                  last: (k == int'(rows[r].len))};
            w_valid = 1'b1;
            do begin
                @(negedge ACLK);
                hs = w_ready;
                @(posedge ACLK);
                #1;
            end while (!hs);
        end
        w_valid = 1'b0;
        w = '0;
        if (t < 0) begin
            // Drain is over once beat number len was taken
            @(negedge ACLK);
            compare_value("w_ready", 32'(w_ready), 32'd0);
            compare_value("b_valid", 32'(b_valid), 32'd1);
            @(posedge ACLK);
            #1;
        end
        b_ready = 1'b1;
        do begin
            @(negedge ACLK);
            hs = b_valid;
            got_b = b;
            @(posedge ACLK);
            #1;
        end while (!hs);
        b_ready = 1'b0;
        @(negedge ACLK);
        if (t >= 0) begin
            compare_value("aw_count", 32'(aw_count[t]), 32'd1);
            compare_value("s_aw.addr", aw_rec[t].addr, rows[r].addr);
            compare_value("s_aw.id", 32'(aw_rec[t].id), 32'({4'h0, rows[r].id}));
            compare_value("s_aw.len", 32'(aw_rec[t].len), 32'(rows[r].len));
            compare_value("s_aw.size", 32'(aw_rec[t].size), 32'd2);
            compare_value("s_aw.burst", 32'(aw_rec[t].burst), 32'd1);
            compare_value("beat_count", 32'(beat_count[t]), 32'(rows[r].len) + 32'd1);
            compare_value("b_count", 32'(b_count[t]), 32'd1);
            for (int k = 0; k <= int'(rows[r].len) && k < beat_count[t]; k++) begin
                compare_value("s_w.data", beat_data[t][k], beat_word(rows[r].seed, k));
                compare_value("s_w.strb", 32'(beat_strb[t][k]), 32'(beat_strobe(k)));
                compare_value("s_w.last", 32'(beat_last[t][k]),
                              32'(k == int'(rows[r].len)));
            end
        end
        compare_value("b.resp", 32'(got_b.resp), 32'(rows[r].resp));
        compare_value("b.id", 32'(got_b.id), 32'(rows[r].id));
        assert (stray_count == 0) else begin
            $display("Error: a slave outside the target saw valid or ready in %0d cycles",
                     stray_count);
            errors++;
        end
        @(posedge ACLK);
        #1;
        if (errors != errs_before) tests_failed++;
        $display("test %0d addr %h len %0d: %s", r, rows[r].addr, rows[r].len,
                 (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        errors = 0;
        tests_failed = 0;
        row_index = 0;
        exp_target = -1;
        ARESETn = 1'b0;
        aw = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        b_ready = 1'b0;
        rows[0] = '{32'h0001_0040, 4'd3,  4'h1, 32'ha5a5_0000, 0,  `RESP_OKAY};
        rows[1] = '{32'h0002_0100, 4'd0,  4'h7, 32'h1234_5678, 1,  `RESP_OKAY};
        rows[2] = '{32'h1000_fffc, 4'd7,  4'hc, 32'hdead_0000, 2,  `RESP_OKAY};
        rows[3] = '{32'h1001_0000, 4'd15, 4'h3, 32'h0f0f_0f0f, 3,  `RESP_OKAY};
        rows[4] = '{32'h20ab_cd00, 4'd5,  4'hf, 32'h8000_0001, 4,  `RESP_OKAY};
        rows[5] = '{32'h3000_0000, 4'd2,  4'h9, 32'h5555_aaaa, -1, `RESP_DECERR};
        rows[6] = '{32'h0001_8000, 4'd1,  4'h5, 32'h7777_0000, 0,  `RESP_OKAY};
        rows[7] = '{32'h1002_0000, 4'd0,  4'ha, 32'h0000_ffff, -1, `RESP_DECERR};
        repeat (2) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;
        @(negedge ACLK);
        compare_value("aw_ready", 32'(aw_ready), 32'd0);
        compare_value("w_ready", 32'(w_ready), 32'd0);
        compare_value("b_valid", 32'(b_valid), 32'd0);
        compare_value("s_aw_valid", 32'(s_aw_valid), 32'd0);
        compare_value("s_w_valid", 32'(s_w_valid), 32'd0);
        compare_value("s_b_ready", 32'(s_b_ready), 32'd0);
        if (errors != 0) tests_failed++;
        $display("test reset: %s", (errors == 0) ? "ok" : "failed");
        @(posedge ACLK);
        #1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("%0d tests run, %0d failed, %0d errors", NUM_ROWS + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, 200 cycles per table row
    initial begin
        repeat (NUM_ROWS * 200 + 10) @(posedge ACLK);
        $display("Timeout: the bridge did not complete the tests in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* source/beat_counter.sv */
/*
 * Counts write beats accepted while draining an unmapped burst.
 * drain_done flags the beat numbered len.
 */
`timescale 1ns/100ps
`include "bridge_macros.svh"

module beat_counter (
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  bridge_pkg::bridge_state_t state,
    input  logic                      w_valid,
    input  logic                      w_ready,
    input  logic [`AXI_LEN_BITS-1:0]  len,
    output logic                      drain_done
);

    logic [`AXI_LEN_BITS-1:0] count;
    logic                     beat;

    assign beat = (state == bridge_pkg::DRAIN) && w_valid && w_ready;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            count <= '0;
        end else if (state != bridge_pkg::DRAIN) begin
            count <= '0;
        end else if (beat) begin
            count <= count + 1'b1;
        end
    end

    assign drain_done = beat && (count == len);

endmodule

/* source/channel_route.sv */
/*
 * Steers one master-to-slave channel to the selected slave.
 * Used for both the write address and the write data channel.
 */
`timescale 1ns/100ps
`include "bridge_macros.svh"

module channel_route #(
    parameter type payload_t = logic
) (
    input  bridge_pkg::bridge_state_t  state,
    input  logic [`SLAVE_SEL_BITS-1:0] target,
    input  payload_t                   payload,
    input  logic                       valid,
    output logic                       ready,
    output payload_t                   s_payload [`NUM_SLAVES],
    output logic [`NUM_SLAVES-1:0]     s_valid,
    input  logic [`NUM_SLAVES-1:0]     s_ready
);

    always_comb begin
        // Idle slaves see an all-zero channel
        for (int i = 0; i < `NUM_SLAVES; i++) begin
            s_payload[i] = '0;
        end
        s_valid = '0;
        ready   = 1'b0;
        if (state == bridge_pkg::ROUTE) begin
            s_payload[target] = payload;
            s_valid[target]   = valid;
            ready             = s_ready[target];
        end
    end

endmodule

/* source/response_merge.sv */
/*
 * Master-facing handshake logic. Returns the routed slave's response,
 * or accepts a drained burst and answers it with DECERR.
 */
`timescale 1ns/100ps
`include "bridge_macros.svh"

module response_merge (
    input  bridge_pkg::bridge_state_t  state,
    input  logic [`SLAVE_SEL_BITS-1:0] target,
    input  logic [`AXI_ID_BITS-1:0]    id,
    input  logic                       aw_open,
    input  logic                       route_aw_ready,
    input  logic                       route_w_ready,
    input  bridge_pkg::b_slave_t       s_b [`NUM_SLAVES],
    input  logic [`NUM_SLAVES-1:0]     s_b_valid,
    input  logic                       b_ready,
    output logic [`NUM_SLAVES-1:0]     s_b_ready,
    output bridge_pkg::b_master_t      b,
    output logic                       b_valid,
    output logic                       aw_ready,
    output logic                       w_ready
);

    always_comb begin
        s_b_ready = '0;
        b         = '0;
        b_valid   = 1'b0;
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        case (state)
            bridge_pkg::ROUTE: begin
                aw_ready          = route_aw_ready;
                w_ready           = route_w_ready;
                // Upper id bits are always zero on the way back
                b.id              = s_b[target].id[`AXI_ID_BITS-1:0];
                b.resp            = s_b[target].resp;
                b_valid           = s_b_valid[target];
                s_b_ready[target] = b_ready;
            end
            bridge_pkg::DRAIN: begin
                aw_ready = aw_open;
                w_ready  = 1'b1;
            end
            bridge_pkg::ERR_RESP: begin
                b.id    = id;
                b.resp  = `RESP_DECERR;
                b_valid = 1'b1;
            end
            default: begin
                b_valid = 1'b0;
            end
        endcase
    end

endmodule

/* write_bridge.f */
+incdir+common
common/bridge_pkg.sv
source/beat_counter.sv
source/channel_route.sv
source/response_merge.sv
write_bridge/addr_decoder.sv
write_bridge/bridge_fsm.sv
write_bridge/write_bridge_top.sv
sim/tb_write_bridge.sv

/* write_bridge/addr_decoder.sv */
/*
 * Address decoder. Latches id, length and the decoded slave index
 * when a write address is offered while the bridge is idle.
 */
`timescale 1ns/100ps
`include "bridge_macros.svh"

module addr_decoder (
    input  logic                       ACLK,
    input  logic                       ARESETn,
    input  bridge_pkg::bridge_state_t  state,
    input  logic                       aw_valid,
    input  bridge_pkg::aw_master_t     aw,
    output logic [`SLAVE_SEL_BITS-1:0] target,
    output logic                       hit,
    output logic [`AXI_LEN_BITS-1:0]   len,
    output logic [`AXI_ID_BITS-1:0]    id
);

    logic [`SLAVE_SEL_BITS-1:0] dec_target;
    logic                       dec_hit;

    always_comb begin
        dec_hit    = 1'b1;
        dec_target = '0;
        if (aw.addr[31:16] == `REGION0_HI) begin
            dec_target = `SLAVE_SEL_BITS'(0);
        end else if (aw.addr[31:16] == `REGION1_HI) begin
            dec_target = `SLAVE_SEL_BITS'(1);
        end else if (aw.addr[31:16] == `REGION2_HI) begin
            dec_target = `SLAVE_SEL_BITS'(2);
        end else if (aw.addr[31:16] == `REGION3_HI) begin
            dec_target = `SLAVE_SEL_BITS'(3);
        end else if (aw.addr[31:24] == `REGION4_HI) begin
            dec_target = `SLAVE_SEL_BITS'(4);
        end else begin
            dec_hit = 1'b0;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            target <= '0;
            hit    <= 1'b0;
        end else if (state == bridge_pkg::IDLE && aw_valid) begin
            target <= dec_target;
            hit    <= dec_hit;
        end
    end

    // Held for the whole transaction
    always_ff @(posedge ACLK) begin
        if (state == bridge_pkg::IDLE && aw_valid) begin
            len <= aw.len;
            id  <= aw.id;
        end
    end

endmodule

/* write_bridge/bridge_fsm.sv */
/*
 * Transaction state machine of the write bridge.
 * Waits one cycle for the registered decode, then routes or drains.
 */
`timescale 1ns/100ps

module bridge_fsm (
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  logic                      aw_valid,
    input  logic                      aw_ready,
    input  logic                      hit,
    input  logic                      drain_done,
    input  logic                      b_valid,
    input  logic                      b_ready,
    output bridge_pkg::bridge_state_t state,
    output logic                      drain_aw_open
);

    bridge_pkg::bridge_state_t next_state;
    logic                      pending;

    always_comb begin
        next_state = state;
        case (state)
            bridge_pkg::IDLE: begin
                // Decode result is valid in the pending cycle
                if (pending) begin
                    next_state = hit ? bridge_pkg::ROUTE : bridge_pkg::DRAIN;
                end
            end
            bridge_pkg::ROUTE,
            bridge_pkg::ERR_RESP: begin
                if (b_valid && b_ready) begin
                    next_state = bridge_pkg::IDLE;
                end
            end
            bridge_pkg::DRAIN: begin
                if (drain_done) begin
                    next_state = bridge_pkg::ERR_RESP;
                end
            end
            default: next_state = bridge_pkg::IDLE;
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state         <= bridge_pkg::IDLE;
            pending       <= 1'b0;
            drain_aw_open <= 1'b0;
        end else begin
            state   <= next_state;
            pending <= (state == bridge_pkg::IDLE) && !pending && aw_valid;
            // Address of an unmapped burst is taken on the first drain cycle
            if (state != bridge_pkg::DRAIN && next_state == bridge_pkg::DRAIN) begin
                drain_aw_open <= 1'b1;
            end else if (aw_valid && aw_ready) begin
                drain_aw_open <= 1'b0;
            end
        end
    end

endmodule

/* write_bridge/write_bridge_top.sv */
/*
 * AXI write bridge, one master to five slaves, one burst in flight.
 * Unmapped addresses are drained and answered with DECERR.
 */
`timescale 1ns/100ps
`include "bridge_macros.svh"

module write_bridge_top (
    input  logic                                ACLK,
    input  logic                                ARESETn,
    // Master side
    input  bridge_pkg::aw_master_t              aw,
    input  logic                                aw_valid,
    output logic                                aw_ready,
    input  bridge_pkg::w_payload_t              w,
    input  logic                                w_valid,
    output logic                                w_ready,
    output bridge_pkg::b_master_t               b,
    output logic                                b_valid,
    input  logic                                b_ready,
    // Slave side
    output bridge_pkg::aw_slave_t               s_aw [`NUM_SLAVES],
    output logic [`NUM_SLAVES-1:0]              s_aw_valid,
    input  logic [`NUM_SLAVES-1:0]              s_aw_ready,
    output bridge_pkg::w_payload_t              s_w [`NUM_SLAVES],
    output logic [`NUM_SLAVES-1:0]              s_w_valid,
    input  logic [`NUM_SLAVES-1:0]              s_w_ready,
    input  bridge_pkg::b_slave_t                s_b [`NUM_SLAVES],
    input  logic [`NUM_SLAVES-1:0]              s_b_valid,
    output logic [`NUM_SLAVES-1:0]              s_b_ready
);

    bridge_pkg::bridge_state_t       state;
    bridge_pkg::aw_slave_t           aw_wide;
    logic [`SLAVE_SEL_BITS-1:0]      target;
    logic                            hit;
    logic [`AXI_LEN_BITS-1:0]        lat_len;
    logic [`AXI_ID_BITS-1:0]         lat_id;
    logic                            drain_done;
    logic                            drain_aw_open;
    logic                            route_aw_ready;
    logic                            route_w_ready;

    // Slave sees the zero-extended id and the latched burst length
    assign aw_wide = '{
        id:    {{(`AXI_IDS_BITS-`AXI_ID_BITS){1'b0}}, aw.id},
        addr:  aw.addr,
        len:   lat_len,
        size:  aw.size,
        burst: aw.burst
    };

    bridge_fsm u_fsm (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .aw_valid      (aw_valid),
        .aw_ready      (aw_ready),
        .hit           (hit),
        .drain_done    (drain_done),
        .b_valid       (b_valid),
        .b_ready       (b_ready),
        .state         (state),
        .drain_aw_open (drain_aw_open)
    );

    addr_decoder u_decoder (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .state    (state),
        .aw_valid (aw_valid),
        .aw       (aw),
        .target   (target),
        .hit      (hit),
        .len      (lat_len),
        .id       (lat_id)
    );

    beat_counter u_beats (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .state      (state),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .len        (lat_len),
        .drain_done (drain_done)
    );

    channel_route #(.payload_t(bridge_pkg::aw_slave_t)) u_aw_route (
        .state     (state),
        .target    (target),
        .payload   (aw_wide),
        .valid     (aw_valid),
        .ready     (route_aw_ready),
        .s_payload (s_aw),
        .s_valid   (s_aw_valid),
        .s_ready   (s_aw_ready)
    );

    channel_route #(.payload_t(bridge_pkg::w_payload_t)) u_w_route (
        .state     (state),
        .target    (target),
        .payload   (w),
        .valid     (w_valid),
        .ready     (route_w_ready),
        .s_payload (s_w),
        .s_valid   (s_w_valid),
        .s_ready   (s_w_ready)
    );

    response_merge u_resp (
        .state          (state),
        .target         (target),
        .id             (lat_id),
        .aw_open        (drain_aw_open),
        .route_aw_ready (route_aw_ready),
        .route_w_ready  (route_w_ready),
        .s_b            (s_b),
        .s_b_valid      (s_b_valid),
        .b_ready        (b_ready),
        .s_b_ready      (s_b_ready),
        .b              (b),
        .b_valid        (b_valid),
        .aw_ready       (aw_ready),
        .w_ready        (w_ready)
    );

endmodule
